//--- include/eval_tb_checks.svh
// ----------------------------------------------------------------------
// Included inside eval_tb after EVAL_WIDTH, first failing check ends run
// ----------------------------------------------------------------------
`ifndef EVAL_TB_CHECKS_SVH
`define EVAL_TB_CHECKS_SVH

// Prints the cause, then the verdict, then stops
task automatic fail_run(input string reason);
   $display("%s", reason);
   $display("*** FAILED ***");
   $fatal(1, "Simulation stopped at first error");
endtask

// Signed score compare, X or Z also mismatch
task automatic check_score(input string                        name,
                           input logic signed [EVAL_WIDTH-1:0] actual,
                           input logic signed [EVAL_WIDTH-1:0] expected);
   if (actual !== expected)
      fail_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
endtask

// Single-bit status compare
task automatic check_flag(input string name,
                          input logic  actual,
                          input logic  expected);
   if (actual !== expected)
      fail_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
endtask

`endif

//--- dv/eval_tb.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Directed tests for eval_top, every board is loaded in full before a start
// ----------------------------------------------------------------------
module eval_tb;
   import eval_pkg::*;

   localparam int EVAL_WIDTH     = 16;
   localparam int NUM_TESTS      = 31;           // One per evaluation, plus reset check
   localparam int RESULT_TIMEOUT = 400;          // Cycles allowed per handshake wait
   localparam int PHASE_CAP      = 62;
   localparam int TAPER_MULT     = 16912;        // 2^20 / 62, rounded down
   localparam int TAPER_DIV      = 1048576;      // 2^20
   localparam int PEN_MG         = 11;           // Doubled pawn, per extra pawn
   localparam int PEN_EG         = 56;
   localparam int MG_TABLE [8]   = '{0, 82, 337, 365, 477, 1025, 0, 0};
   localparam int EG_TABLE [8]   = '{0, 94, 281, 297, 512, 936, 0, 0};
   localparam piece_t BACK_RANK [8] = '{w_rook, w_knight, w_bishop, w_queen,
                                        w_king, w_bishop, w_knight, w_rook};
   localparam piece_t PIECES [12] = '{w_pawn, w_knight, w_bishop, w_rook, w_queen, w_king,
                                      b_pawn, b_knight, b_bishop, b_rook, b_queen, b_king};

   logic                         clk;
   logic                         reset;
   logic                         load_valid;
   logic                         load_ready;
   square_t                      load_square;
   piece_t                       load_piece;
   logic                         start_valid;
   logic                         start_ready;
   logic                         white_to_move;
   logic                         eval_valid;
   logic                         eval_ready;
   logic signed [EVAL_WIDTH-1:0] eval;
   piece_t                       board_img [64];   // Board to load and to score

   `include "eval_tb_checks.svh"

   eval_top #(.EVAL_WIDTH(EVAL_WIDTH)) uut (
      .clk           (clk),
      .reset         (reset),
      .load_valid    (load_valid),
      .load_ready    (load_ready),
      .load_square   (load_square),
      .load_piece    (load_piece),
      .start_valid   (start_valid),
      .start_ready   (start_ready),
      .white_to_move (white_to_move),
      .eval_valid    (eval_valid),
      .eval_ready    (eval_ready),
      .eval          (eval)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;                     // 10 ns period
   end

   initial
   begin
      repeat (NUM_TESTS * RESULT_TIMEOUT) @(posedge clk);
      fail_run("Watchdog expired before all tests finished");
   end

   // Material, doubled pawns, phase taper, side to move
   function automatic logic signed [EVAL_WIDTH-1:0] eval_model(input logic wtm);
      int     mg;
      int     eg;
      int     count;
      int     ptype;
      int     phase;
      int     w_pawns [8];
      int     b_pawns [8];
      longint acc;
      longint tapered;
      mg    = 0;
      eg    = 0;
      count = 0;
      for (int f = 0; f < 8; f++)
      begin
         w_pawns[f] = 0;
         b_pawns[f] = 0;
      end
      for (int sq = 0; sq < 64; sq++)
      begin
         ptype = int'(board_img[sq][2:0]);
         if (board_img[sq][3])                   // Black piece
         begin
            mg -= MG_TABLE[ptype];
            eg -= EG_TABLE[ptype];
            if (ptype == 1)
               b_pawns[sq % 8]++;
         end
         else
         begin
            mg += MG_TABLE[ptype];
            eg += EG_TABLE[ptype];
            if (ptype == 1)
               w_pawns[sq % 8]++;
         end
         if (ptype > 1)
            count++;                             // Kings count too
      end
      for (int f = 0; f < 8; f++)
      begin
         if (w_pawns[f] > 1)
         begin
            mg -= PEN_MG * (w_pawns[f] - 1);
            eg -= PEN_EG * (w_pawns[f] - 1);
         end
         if (b_pawns[f] > 1)
         begin
            mg += PEN_MG * (b_pawns[f] - 1);
            eg += PEN_EG * (b_pawns[f] - 1);
         end
      end
      phase   = (count > PHASE_CAP) ? PHASE_CAP : count;
      acc     = longint'(mg) * phase + longint'(eg) * (PHASE_CAP - phase);
      tapered = (acc * TAPER_MULT) / TAPER_DIV;  // Truncates toward zero
      if (!wtm)
         tapered = -tapered;
      return tapered[EVAL_WIDTH-1:0];
   endfunction

   task automatic set_start_position();
      for (int sq = 0; sq < 64; sq++)
         board_img[sq] = sq_empty;
      for (int f = 0; f < 8; f++)
      begin
         board_img[f]      = BACK_RANK[f];
         board_img[8 + f]  = w_pawn;
         board_img[48 + f] = b_pawn;
         board_img[56 + f] = piece_t'({1'b1, BACK_RANK[f][2:0]});   // Same type, black
      end
   endtask

   task automatic randomize_board();
      for (int sq = 0; sq < 64; sq++)
         board_img[sq] = ($urandom_range(0, 1) == 1) ? PIECES[$urandom_range(0, 11)] : sq_empty;
   endtask

   task automatic load_board();
      int wait_cnt;
      for (int sq = 0; sq < 64; sq++)
      begin
         load_valid  = 1'b1;
         load_square = square_t'(sq);
         load_piece  = board_img[sq];
         wait_cnt    = 0;
         while (!load_ready)                     // Ready is stable until the edge
         begin
            @(posedge clk);
            #1;
            wait_cnt++;
            if (wait_cnt > RESULT_TIMEOUT)
               fail_run("Board load was never accepted");
         end
         @(posedge clk);
         #1;
      end
      load_valid = 1'b0;
   endtask

   task automatic start_eval(input logic wtm);
      logic accepted;
      int   wait_cnt;
      start_valid   = 1'b1;
      white_to_move = wtm;
      wait_cnt      = 0;
      do
      begin
         accepted = start_ready;                 // Taken on the coming edge
         @(posedge clk);
         #1;
         wait_cnt++;
         if (wait_cnt > RESULT_TIMEOUT)
            fail_run("Start was never accepted");
      end
      while (!accepted);
      start_valid = 1'b0;
   endtask

   task automatic wait_result(output logic signed [EVAL_WIDTH-1:0] result);
      int wait_cnt;
      wait_cnt = 0;
      while (!eval_valid)
      begin
         @(posedge clk);
         #1;
         wait_cnt++;
         if (wait_cnt > RESULT_TIMEOUT)
            fail_run("No result arrived after the start");
      end
      result = eval;
   endtask

   task automatic release_result();
      eval_ready = 1'b1;
      @(posedge clk);
      #1;
      eval_ready = 1'b0;
      check_flag("eval_valid", eval_valid, 1'b0);   // Dropped after handshake
      check_flag("start_ready", start_ready, 1'b1);
   endtask

   task automatic run_eval(input logic wtm, output logic signed [EVAL_WIDTH-1:0] result);
      start_eval(wtm);
      wait_result(result);
      release_result();
   endtask

   task automatic eval_and_check(input logic wtm);
      logic signed [EVAL_WIDTH-1:0] got;
      run_eval(wtm, got);
      check_score("eval", got, eval_model(wtm));
   endtask

   task automatic test_reset_state();
      check_flag("eval_valid", eval_valid, 1'b0);
      check_flag("load_ready", load_ready, 1'b1);
      check_flag("start_ready", start_ready, 1'b1);
   endtask

   task automatic test_start_position();
      logic signed [EVAL_WIDTH-1:0] got;
      set_start_position();
      load_board();
      run_eval(1'b1, got);
      check_score("eval", got, '0);             // Balanced, no pawn faults
      run_eval(1'b0, got);
      check_score("eval", got, '0);
   endtask

   task automatic test_extra_queen();
      logic signed [EVAL_WIDTH-1:0] got_w;
      logic signed [EVAL_WIDTH-1:0] got_b;
      set_start_position();
      board_img[27] = w_queen;                   // d4
      load_board();
      run_eval(1'b1, got_w);
      check_score("eval", got_w, eval_model(1'b1));
      run_eval(1'b0, got_b);
      check_score("eval", got_b, eval_model(1'b0));   // Black's view, negated
   endtask

   task automatic test_doubled_pawns();
      set_start_position();
      board_img[17] = w_pawn;                    // b-file doubled
      board_img[18] = w_pawn;                    // c-file tripled
      board_img[26] = w_pawn;
      load_board();
      eval_and_check(1'b1);
      set_start_position();
      board_img[44] = b_pawn;                    // e-file doubled
      board_img[37] = b_pawn;                    // f-file tripled
      board_img[45] = b_pawn;
      load_board();
      eval_and_check(1'b0);
      set_start_position();
      board_img[17] = w_pawn;
      board_img[18] = w_pawn;
      board_img[26] = w_pawn;
      board_img[44] = b_pawn;
      load_board();
      eval_and_check(1'b1);
      for (int sq = 0; sq < 64; sq++)
         board_img[sq] = (sq % 2 == 1) ? b_bishop : w_knight;   // 64 officers, phase clamps
      load_board();
      eval_and_check(1'b0);
   endtask

   task automatic test_back_pressure();
      logic signed [EVAL_WIDTH-1:0] held;
      logic                         wtm;
      int                           hold_cycles;
      randomize_board();
      wtm = ($urandom_range(0, 1) == 1);
      load_board();
      start_eval(wtm);
      wait_result(held);
      check_score("eval", held, eval_model(wtm));
      hold_cycles = $urandom_range(1, 20);
      repeat (hold_cycles)
      begin
         @(posedge clk);
         #1;
         check_flag("eval_valid", eval_valid, 1'b1);
         check_flag("start_ready", start_ready, 1'b0);
         check_flag("load_ready", load_ready, 1'b0);
         check_score("eval", eval, held);        // Must not move while stalled
      end
      release_result();
      randomize_board();
      load_board();
      eval_and_check(!wtm);
   endtask

   task automatic test_random_boards();
      for (int n = 0; n < 20; n++)
      begin
         randomize_board();
         load_board();
         eval_and_check($urandom_range(0, 1) == 1);
      end
   endtask

   initial
   begin
      void'($urandom(32'hdeb7));
      reset         = 1'b1;
      load_valid    = 1'b0;
      load_square   = '0;
      load_piece    = sq_empty;
      start_valid   = 1'b0;
      white_to_move = 1'b0;
      eval_ready    = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset_state();
      test_start_position();
      test_extra_queen();
      test_doubled_pawns();
      test_back_pressure();
      test_random_boards();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- hw/board_ram.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Contents are undefined after reset, load all squares before a start
// ---------------------------------------------------------------------
module board_ram
(
   input  logic              clk,
   input  logic              wr_en,
   input  eval_pkg::square_t wr_addr,
   input  eval_pkg::piece_t  wr_data,
   input  logic              rd_en,
   input  eval_pkg::square_t rd_addr,
   output eval_pkg::piece_t  rd_data
);
   import eval_pkg::*;

   piece_t mem [64];                             // One code per square

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;               // Load port, idle only
      if (rd_en)
         rd_data <= mem[rd_addr];               // Registered read, 1 cycle
   end

endmodule

//--- hw/eval_pkg.sv
// ---------------------------------------------------------------------
// Square codes use bit 3 for colour (1 = black), bits 2..0 for type
// Value tables are indexed by the 3-bit type, types 0 and 7 score zero
// ---------------------------------------------------------------------
package eval_pkg;

   typedef enum logic [3:0] {
      sq_empty = 4'd0,
      w_pawn   = 4'd1,
      w_knight = 4'd2,
      w_bishop = 4'd3,
      w_rook   = 4'd4,
      w_queen  = 4'd5,
      w_king   = 4'd6,
      b_pawn   = 4'd9,
      b_knight = 4'd10,
      b_bishop = 4'd11,
      b_rook   = 4'd12,
      b_queen  = 4'd13,
      b_king   = 4'd14
   } piece_t;

   typedef logic [5:0] square_t;                // Rank * 8 + file

   typedef enum logic [2:0] {
      st_idle,                                   // Board load and start accepted here
      st_scan,                                   // Both scanners walking the board
      st_wait_blend,                             // Blend pipeline in flight
      st_hold                                    // Result offered until eval_ready
   } ctrl_state_t;

   // Middle-game piece values: empty, P, N, B, R, Q, K, unused
   localparam logic [15:0] MG_VALUE [8] = '{
      16'd0, 16'd82, 16'd337, 16'd365, 16'd477, 16'd1025, 16'd0, 16'd0
   };

   // End-game piece values, same order
   localparam logic [15:0] EG_VALUE [8] = '{
      16'd0, 16'd94, 16'd281, 16'd297, 16'd512, 16'd936, 16'd0, 16'd0
   };

   localparam logic [15:0] DOUBLED_MG  = 16'd11;     // Per extra pawn on a file
   localparam logic [15:0] DOUBLED_EG  = 16'd56;
   localparam logic [7:0]  PHASE_MAX   = 8'd62;      // Phase clamp and taper divisor
   localparam logic [31:0] PHASE_RECIP = 32'd16912;  // 2^20 / 62, rounded down
   localparam logic [31:0] RECIP_SHIFT = 32'd20;

   localparam int NUM_SCANNERS = 2;                  // Requesters on the board memory

endpackage

//--- hw/eval_top.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Load and start are taken only in idle; eval holds until eval_ready
// ---------------------------------------------------------------------
module eval_top #(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         load_valid,
   output logic                         load_ready,
   input  eval_pkg::square_t            load_square,
   input  eval_pkg::piece_t             load_piece,
   input  logic                         start_valid,
   output logic                         start_ready,
   input  logic                         white_to_move,
   output logic                         eval_valid,
   input  logic                         eval_ready,
   output logic signed [EVAL_WIDTH-1:0] eval
);
   import eval_pkg::*;

   ctrl_state_t                  state;
   logic                         start_accept;
   logic                         wtm_r;          // Side to move for this evaluation
   logic                         scan_start;
   logic                         blend_valid;
   logic                         blend_out_valid;
   logic [NUM_SCANNERS-1:0]      done_lock;      // Bit 0 material, bit 1 pawns
   logic [NUM_SCANNERS-1:0]      rd_req;
   logic [NUM_SCANNERS-1:0]      rd_gnt;
   logic [NUM_SCANNERS-1:0]      rd_rvalid;
   square_t                      mat_addr;
   square_t                      pawn_addr;
   square_t                      ram_addr;
   logic                         ram_en;
   piece_t                       rd_data;
   logic                         mat_done;
   logic                         pawn_done;
   logic [6:0]                   piece_count;
   logic signed [EVAL_WIDTH-1:0] mat_mg;
   logic signed [EVAL_WIDTH-1:0] mat_eg;
   logic signed [EVAL_WIDTH-1:0] pawn_mg;
   logic signed [EVAL_WIDTH-1:0] pawn_eg;
   logic signed [EVAL_WIDTH-1:0] score;

   assign load_ready   = (state == st_idle);
   assign start_ready  = (state == st_idle);
   assign start_accept = start_valid && start_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= st_idle;
         scan_start  <= 1'b0;
         blend_valid <= 1'b0;
         eval_valid  <= 1'b0;
         done_lock   <= '0;
      end
      else
      begin
         scan_start  <= 1'b0;                   // Both are single-cycle pulses
         blend_valid <= 1'b0;
         case (state)
            st_idle:
               if (start_accept)
               begin
                  scan_start <= 1'b1;
                  done_lock  <= '0;
                  state      <= st_scan;
               end
            st_scan:
            begin
               done_lock <= done_lock | {pawn_done, mat_done};
               if (&done_lock)
               begin
                  blend_valid <= 1'b1;          // Sums are held by the scanners
                  state       <= st_wait_blend;
               end
            end
            st_wait_blend:
               if (blend_out_valid)
               begin
                  eval_valid <= 1'b1;
                  state      <= st_hold;
               end
            st_hold:
               if (eval_ready)
               begin
                  eval_valid <= 1'b0;
                  state      <= st_idle;
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_accept)
         wtm_r <= white_to_move;
      if ((state == st_wait_blend) && blend_out_valid)
         eval <= score;                         // Result hold register
   end

   board_ram u_board_ram (
      .clk     (clk),
      .wr_en   (load_valid && load_ready),
      .wr_addr (load_square),
      .wr_data (load_piece),
      .rd_en   (ram_en),
      .rd_addr (ram_addr),
      .rd_data (rd_data)
   );

   square_arbiter u_arbiter (
      .clk       (clk),
      .reset     (reset),
      .rd_req    (rd_req),
      .rd_addr0  (mat_addr),
      .rd_addr1  (pawn_addr),
      .rd_gnt    (rd_gnt),
      .rd_rvalid (rd_rvalid),
      .ram_en    (ram_en),
      .ram_addr  (ram_addr)
   );

   material_scan #(.EVAL_WIDTH(EVAL_WIDTH)) u_material (
      .clk         (clk),
      .reset       (reset),
      .scan_start  (scan_start),
      .rd_req      (rd_req[0]),
      .rd_addr     (mat_addr),
      .rd_gnt      (rd_gnt[0]),
      .rd_rvalid   (rd_rvalid[0]),
      .rd_data     (rd_data),
      .mg_sum      (mat_mg),
      .eg_sum      (mat_eg),
      .piece_count (piece_count),
      .done        (mat_done)
   );

   pawn_scan #(.EVAL_WIDTH(EVAL_WIDTH)) u_pawns (
      .clk        (clk),
      .reset      (reset),
      .scan_start (scan_start),
      .rd_req     (rd_req[1]),
      .rd_addr    (pawn_addr),
      .rd_gnt     (rd_gnt[1]),
      .rd_rvalid  (rd_rvalid[1]),
      .rd_data    (rd_data),
      .mg_sum     (pawn_mg),
      .eg_sum     (pawn_eg),
      .done       (pawn_done)
   );

   phase_blend #(.EVAL_WIDTH(EVAL_WIDTH)) u_blend (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (blend_valid),
      .mg_a          (mat_mg),
      .eg_a          (mat_eg),
      .mg_b          (pawn_mg),
      .eg_b          (pawn_eg),
      .piece_count   (piece_count),
      .white_to_move (wtm_r),
      .out_valid     (blend_out_valid),
      .score         (score)
   );

endmodule

//--- hw/material_scan.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Sums hold until the next scan_start; count takes every square whose
// type is neither empty nor pawn, kings included
// ---------------------------------------------------------------------
module material_scan #(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         scan_start,
   output logic                         rd_req,
   output eval_pkg::square_t            rd_addr,
   input  logic                         rd_gnt,
   input  logic                         rd_rvalid,
   input  eval_pkg::piece_t             rd_data,
   output logic signed [EVAL_WIDTH-1:0] mg_sum,
   output logic signed [EVAL_WIDTH-1:0] eg_sum,
   output logic [6:0]                   piece_count,
   output logic                         done
);
   import eval_pkg::*;

   logic [5:0]                   issue_addr;    // Next square to request
   logic [5:0]                   recv_cnt;      // Squares returned so far
   logic [2:0]                   ptype;
   logic                         is_black;
   logic                         is_officer;    // Counts toward game phase
   logic signed [EVAL_WIDTH-1:0] mg_val;
   logic signed [EVAL_WIDTH-1:0] eg_val;

   assign rd_addr    = issue_addr;
   assign ptype      = rd_data[2:0];
   assign is_black   = rd_data[3];
   assign is_officer = (ptype != 3'(sq_empty)) && (ptype != 3'(w_pawn));
   assign mg_val     = MG_VALUE[ptype];         // Zero extended, always positive
   assign eg_val     = EG_VALUE[ptype];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_req     <= 1'b0;
         done       <= 1'b0;
         issue_addr <= '0;
         recv_cnt   <= '0;
      end
      else
      begin
         done <= rd_rvalid && (recv_cnt == 6'd63);   // Last square arrived
         if (scan_start)
         begin
            rd_req     <= 1'b1;
            issue_addr <= '0;
            recv_cnt   <= '0;
         end
         else
         begin
            if (rd_gnt)
            begin
               issue_addr <= issue_addr + 6'd1;
               if (issue_addr == 6'd63)
                  rd_req <= 1'b0;               // All 64 addresses issued
            end
            if (rd_rvalid)
               recv_cnt <= recv_cnt + 6'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         mg_sum      <= '0;
         eg_sum      <= '0;
         piece_count <= '0;
      end
      else if (rd_rvalid)
      begin
         mg_sum <= is_black ? mg_sum - mg_val : mg_sum + mg_val;
         eg_sum <= is_black ? eg_sum - eg_val : eg_sum + eg_val;
         if (is_officer)
            piece_count <= piece_count + 7'd1;
      end
   end

endmodule

//--- hw/pawn_scan.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Walks the board, then spends 8 cycles on the files before done
// Each pawn beyond the first on a file costs its own side the penalty
// ---------------------------------------------------------------------
module pawn_scan #(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         scan_start,
   output logic                         rd_req,
   output eval_pkg::square_t            rd_addr,
   input  logic                         rd_gnt,
   input  logic                         rd_rvalid,
   input  eval_pkg::piece_t             rd_data,
   output logic signed [EVAL_WIDTH-1:0] mg_sum,
   output logic signed [EVAL_WIDTH-1:0] eg_sum,
   output logic                         done
);
   import eval_pkg::*;

   logic [5:0]                   issue_addr;    // Next square to request
   logic [5:0]                   recv_cnt;      // Also gives file of returned square
   logic [3:0]                   pawn_cnt [2][8];   // [colour][file], up to 8 each
   logic                         tally;         // File pass in progress
   logic [2:0]                   tally_file;
   logic                         is_pawn;
   logic [3:0]                   w_cnt;
   logic [3:0]                   b_cnt;
   logic [3:0]                   w_extra;
   logic [3:0]                   b_extra;
   logic signed [EVAL_WIDTH-1:0] mg_step;
   logic signed [EVAL_WIDTH-1:0] eg_step;

   assign rd_addr = issue_addr;
   assign is_pawn = (rd_data == w_pawn) || (rd_data == b_pawn);
   assign w_cnt   = pawn_cnt[0][tally_file];
   assign b_cnt   = pawn_cnt[1][tally_file];
   assign w_extra = (w_cnt > 4'd1) ? w_cnt - 4'd1 : 4'd0;
   assign b_extra = (b_cnt > 4'd1) ? b_cnt - 4'd1 : 4'd0;
   assign mg_step = b_extra * DOUBLED_MG - w_extra * DOUBLED_MG;   // Black extras help white
   assign eg_step = b_extra * DOUBLED_EG - w_extra * DOUBLED_EG;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_req     <= 1'b0;
         done       <= 1'b0;
         tally      <= 1'b0;
         tally_file <= '0;
         issue_addr <= '0;
         recv_cnt   <= '0;
      end
      else
      begin
         done <= 1'b0;
         if (scan_start)
         begin
            rd_req     <= 1'b1;
            tally      <= 1'b0;
            issue_addr <= '0;
            recv_cnt   <= '0;
         end
         else
         begin
            if (rd_gnt)
            begin
               issue_addr <= issue_addr + 6'd1;
               if (issue_addr == 6'd63)
                  rd_req <= 1'b0;
            end
            if (rd_rvalid)
               recv_cnt <= recv_cnt + 6'd1;
            if (rd_rvalid && (recv_cnt == 6'd63))
            begin
               tally      <= 1'b1;              // Board done, start file pass
               tally_file <= '0;
            end
            else if (tally)
            begin
               tally_file <= tally_file + 3'd1;
               if (tally_file == 3'd7)
               begin
                  tally <= 1'b0;
                  done  <= 1'b1;                // Sums final on this edge
               end
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         pawn_cnt <= '{default: '0};
         mg_sum   <= '0;
         eg_sum   <= '0;
      end
      else
      begin
         if (rd_rvalid && is_pawn)
            pawn_cnt[rd_data[3]][recv_cnt[2:0]] <= pawn_cnt[rd_data[3]][recv_cnt[2:0]] + 4'd1;
         if (tally)
         begin
            mg_sum <= mg_sum + mg_step;
            eg_sum <= eg_sum + eg_step;
         end
      end
   end

endmodule

//--- hw/phase_blend.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Fixed 5-cycle latency, no stall; division truncates toward zero
// ---------------------------------------------------------------------
module phase_blend #(
   parameter int EVAL_WIDTH = 16
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         in_valid,
   input  logic signed [EVAL_WIDTH-1:0] mg_a,
   input  logic signed [EVAL_WIDTH-1:0] eg_a,
   input  logic signed [EVAL_WIDTH-1:0] mg_b,
   input  logic signed [EVAL_WIDTH-1:0] eg_b,
   input  logic [6:0]                   piece_count,
   input  logic                         white_to_move,
   output logic                         out_valid,
   output logic signed [EVAL_WIDTH-1:0] score
);
   import eval_pkg::*;

   localparam int SUM_W  = EVAL_WIDTH + 1;       // mg or eg of both scanners
   localparam int PROD_W = SUM_W + 9;            // Times 9-bit signed phase
   localparam int ACC_W  = PROD_W + 1;
   localparam int MULT_W = ACC_W + 33;           // Times 33-bit signed reciprocal

   logic [4:0]               vld;                // Valid per stage
   logic [3:0]               wtm;                // Side to move, stages 1..4
   logic [7:0]               phase_in;
   logic signed [SUM_W-1:0]  mg_s1;
   logic signed [SUM_W-1:0]  eg_s1;
   logic [7:0]               phase_s1;
   logic signed [PROD_W-1:0] mg_s2;
   logic signed [PROD_W-1:0] eg_s2;
   logic signed [ACC_W-1:0]  acc_s3;
   logic signed [MULT_W-1:0] scaled;
   logic signed [MULT_W-1:0] round_bias;
   logic signed [MULT_W-1:0] quotient;
   logic signed [EVAL_WIDTH-1:0] tapered_s4;

   assign phase_in   = ({1'b0, piece_count} > PHASE_MAX) ? PHASE_MAX : {1'b0, piece_count};
   assign scaled     = acc_s3 * $signed({1'b0, PHASE_RECIP});
   // Negative values get 2^20-1 added so the shift rounds toward zero
   assign round_bias = {MULT_W{scaled[MULT_W-1]}} & MULT_W'((64'd1 << RECIP_SHIFT) - 64'd1);
   assign quotient   = (scaled + round_bias) >>> RECIP_SHIFT;
   assign out_valid  = vld[4];

   always_ff @(posedge clk)
   begin
      if (reset)
         vld <= '0;
      else
         vld <= {vld[3:0], in_valid};
   end

   always_ff @(posedge clk)
   begin
      wtm        <= {wtm[2:0], white_to_move};
      mg_s1      <= mg_a + mg_b;                // Stage 1 combine and clamp
      eg_s1      <= eg_a + eg_b;
      phase_s1   <= phase_in;
      mg_s2      <= mg_s1 * $signed({1'b0, phase_s1});   // Stage 2 taper weights
      eg_s2      <= eg_s1 * $signed({1'b0, PHASE_MAX - phase_s1});
      acc_s3     <= mg_s2 + eg_s2;              // Stage 3
      tapered_s4 <= quotient[EVAL_WIDTH-1:0];  // Stage 4 divide by 62
      score      <= wtm[3] ? tapered_s4 : -tapered_s4;   // Stage 5 side to move
   end

endmodule

//--- hw/square_arbiter.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// One grant per cycle, read data returns on the next cycle with rd_rvalid
// ---------------------------------------------------------------------
module square_arbiter
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [eval_pkg::NUM_SCANNERS-1:0] rd_req,
   input  eval_pkg::square_t                 rd_addr0,
   input  eval_pkg::square_t                 rd_addr1,
   output logic [eval_pkg::NUM_SCANNERS-1:0] rd_gnt,
   output logic [eval_pkg::NUM_SCANNERS-1:0] rd_rvalid,
   output logic                              ram_en,
   output eval_pkg::square_t                 ram_addr
);

   logic last_winner;                            // Requester served most recently

   always_comb
   begin
      rd_gnt = '0;
      if (rd_req[0] && rd_req[1])
      begin
         if (last_winner)
            rd_gnt[0] = 1'b1;                   // Requester 1 had the last turn
         else
            rd_gnt[1] = 1'b1;
      end
      else
         rd_gnt = rd_req;                       // Lone requester always wins
   end

   assign ram_en   = |rd_req;
   assign ram_addr = rd_gnt[1] ? rd_addr1 : rd_addr0;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_winner <= 1'b0;
         rd_rvalid   <= '0;
      end
      else
      begin
         rd_rvalid <= rd_gnt;                   // Steer data back to the served one
         if (rd_gnt[1])
            last_winner <= 1'b1;
         else if (rd_gnt[0])
            last_winner <= 1'b0;
      end
   end

endmodule

//--- list.f
+incdir+include
hw/eval_pkg.sv
hw/board_ram.sv
hw/square_arbiter.sv
hw/material_scan.sv
hw/pawn_scan.sv
hw/phase_blend.sv
hw/eval_top.sv
dv/eval_tb.sv
